//--- src.f
+incdir+rtl
rtl/gat_debug_pkg.sv
rtl/debug_ctrl.sv
rtl/stage_hs_monitor.sv
rtl/bram_watch.sv
rtl/debug_readout.sv
rtl/gat_debugger.sv
tests/gat_debugger_sva.sv
tests/tb_gat_debugger.sv

//--- Bender.yml
package:
  name: gat_debugger

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/gat_debug_pkg.sv
      - rtl/debug_ctrl.sv
      - rtl/stage_hs_monitor.sv
      - rtl/bram_watch.sv
      - rtl/debug_readout.sv
      - rtl/gat_debugger.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/gat_debugger_sva.sv
      - tests/tb_gat_debugger.sv

//--- tests/tb_gat_debugger.sv
`include "gat_debug_defs.svh"

module tb_gat_debugger;

  import gat_debug_pkg::*;

  localparam int NS = `GAT_DBG_NUM_STAGES;
  // Reset, identity, gate, counting, capture, feature, freeze/clear.
  localparam int TEST_CYCLES = 20 + 80 + 80 + 400 + 80 + 80 + 200;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic              clk;
  logic              rst_n;
  logic              arm_i;
  logic              freeze_i;
  logic              clear_i;
  stage_vec_t        stage_vld_i;
  stage_vec_t        stage_rdy_i;
  wh_addr_t          wh_addr_i;
  sppe_lane_t [15:0] sppe_i;
  logic              feat_ena_i;
  feat_addr_t        feat_addr_i;
  reg_sel_t          sel_i;
  dbg_word_t         rdata_o;
  dbg_state_e        state_o;

  dbg_state_e        ref_state;
  dbg_cnt_t [NS-1:0] ref_xfer;
  dbg_cnt_t [NS-1:0] ref_stall;
  stage_vec_t        ref_vld;
  stage_vec_t        ref_rdy;
  logic              ref_wr;
  logic              ref_hi;
  sppe_lane_t        ref_cap_a;
  sppe_lane_t        ref_cap_b;

  logic      chk_en;
  dbg_word_t exp_word;
  string     test_name;
  int        err_cnt   = 0;
  int        check_cnt = 0;
  int        test_cnt  = 0;
  int        test_err0 = 0;
  int        cycle_cnt = 0;
  integer    seed      = 84815;

  gat_debugger UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .arm_i       (arm_i),
    .freeze_i    (freeze_i),
    .clear_i     (clear_i),
    .stage_vld_i (stage_vld_i),
    .stage_rdy_i (stage_rdy_i),
    .wh_addr_i   (wh_addr_i),
    .sppe_i      (sppe_i),
    .feat_ena_i  (feat_ena_i),
    .feat_addr_i (feat_addr_i),
    .sel_i       (sel_i),
    .rdata_o     (rdata_o),
    .state_o     (state_o)
  );

  bind gat_debugger gat_debugger_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel_i       (sel_i),
    .rdata_i     (rdata_o),
    .state_i     (state_o),
    .xfer_cnt_i  (xfer_cnt),
    .stall_cnt_i (stall_cnt)
  );

  always #50 clk = ~clk;

  // ==============================
  // Reference model
  // ==============================
  // Clear behaves like reset; nothing is recorded outside the armed state.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n || clear_i) begin
      ref_state <= DBG_IDLE;
      ref_xfer  <= '0;
      ref_stall <= '0;
      ref_vld   <= '0;
      ref_rdy   <= '0;
      ref_wr    <= 1'b0;
      ref_hi    <= 1'b0;
      ref_cap_a <= '0;
      ref_cap_b <= '0;
    end else begin
      if (ref_state == DBG_ARMED) begin
        ref_vld <= ref_vld | stage_vld_i;
        ref_rdy <= ref_rdy | stage_rdy_i;
        ref_wr  <= ref_wr | feat_ena_i;
        ref_hi  <= ref_hi | (feat_ena_i && feat_addr_i >= `GAT_DBG_FEAT_HI_ADDR);
        for (int s = 0; s < NS; s++) begin
          if (stage_vld_i[s] && stage_rdy_i[s])
            ref_xfer[s] <= ref_xfer[s] + 1;
          if (stage_vld_i[s] && !stage_rdy_i[s])
            ref_stall[s] <= ref_stall[s] + 1;
        end
        if (stage_rdy_i[0] && wh_addr_i == `GAT_DBG_CAP_ADDR_A)
          ref_cap_a <= sppe_i[`GAT_DBG_SPPE_LANE];
        if (stage_rdy_i[0] && wh_addr_i == `GAT_DBG_CAP_ADDR_B)
          ref_cap_b <= sppe_i[`GAT_DBG_SPPE_LANE];
      end
      if (ref_state == DBG_IDLE && arm_i)
        ref_state <= DBG_ARMED;
      else if (ref_state == DBG_ARMED && freeze_i)
        ref_state <= DBG_FROZEN;
    end
  end

  function automatic dbg_word_t expected_word(input reg_sel_t idx);
    dbg_word_t w;
    w = '0;
    case (idx)
      `GAT_DBG_REG_ID:     w = `GAT_DBG_SIGNATURE;
      `GAT_DBG_REG_CFG:    w = 32'd12;
      `GAT_DBG_REG_STATUS: begin
        // Spmm flags in bits 7:6, aggr in bits 1:0.
        for (int s = 0; s < NS; s++) begin
          w[7 - 2*s] = ref_vld[s];
          w[6 - 2*s] = ref_rdy[s];
        end
        w[8]     = ref_wr;
        w[9]     = ref_hi;
        w[11:10] = ref_state;
      end
      4'd3, 4'd4, 4'd5, 4'd6:  w = ref_xfer[idx - 4'd3];
      4'd7, 4'd8, 4'd9, 4'd10: w = ref_stall[idx - 4'd7];
      `GAT_DBG_REG_CAP_A:  w = {20'd0, ref_cap_a};
      `GAT_DBG_REG_CAP_B:  w = {20'd0, ref_cap_b};
      default:             w = '0;
    endcase
    return w;
  endfunction

  // ==============================
  // Stimulus helpers
  // ==============================
  task automatic idle_inputs();
    arm_i       = 1'b0;
    freeze_i    = 1'b0;
    clear_i     = 1'b0;
    stage_vld_i = '0;
    stage_rdy_i = '0;
    wh_addr_i   = '0;
    feat_ena_i  = 1'b0;
    feat_addr_i = '0;
  endtask

  task automatic pulse_control(input logic arm, input logic freeze, input logic clear);
    @(negedge clk);
    arm_i    = arm;
    freeze_i = freeze;
    clear_i  = clear;
    @(negedge clk);
    arm_i    = 1'b0;
    freeze_i = 1'b0;
    clear_i  = 1'b0;
  endtask

  task automatic drive_strobes(input stage_vec_t vld, input stage_vec_t rdy);
    @(negedge clk);
    stage_vld_i = vld;
    stage_rdy_i = rdy;
  endtask

  // Check lands on the rising edge after the one that registers sel_i.
  task automatic read_word(input reg_sel_t idx);
    @(negedge clk);
    sel_i    = idx;
    exp_word = expected_word(idx);
    @(negedge clk);
    chk_en = 1'b1;
    check_cnt++;
    @(negedge clk);
    chk_en = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    $display("%-16s %s, %0d errors", test_name,
             (err_cnt == test_err0) ? "ok" : "failed", err_cnt - test_err0);
  endtask

  initial begin : watchdog
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    sel_i    = '0;
    sppe_i   = '0;
    chk_en   = 1'b0;
    exp_word = '0;
    idle_inputs();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_identity");
    for (int i = 0; i < 16; i++)
      read_word(reg_sel_t'(i));
    end_test();

    start_test("record_gate");
    drive_strobes('1, '1);
    drive_strobes('0, '0);
    read_word(`GAT_DBG_REG_STATUS);
    pulse_control(1'b1, 1'b0, 1'b0);
    drive_strobes(4'b0101, 4'b1010);
    drive_strobes('0, '0);
    read_word(`GAT_DBG_REG_STATUS);
    drive_strobes(4'b1010, 4'b0101);
    drive_strobes('0, '0);
    repeat (3) @(negedge clk);
    read_word(`GAT_DBG_REG_STATUS);
    end_test();

    start_test("counting");
    repeat (200)
      drive_strobes(stage_vec_t'($random(seed)), stage_vec_t'($random(seed)));
    drive_strobes('0, '0);
    for (int i = 3; i <= 10; i++)
      read_word(reg_sel_t'(i));
    end_test();

    start_test("capture");
    stage_rdy_i = 4'b0001;
    for (int i = 0; i < 24; i++) begin
      @(negedge clk);
      wh_addr_i = wh_addr_t'(8 + i % 14);
      for (int l = 0; l < 16; l++)
        sppe_i[l] = sppe_lane_t'($random(seed));
    end
    // Address A while spmm is not ready must be ignored.
    @(negedge clk);
    stage_rdy_i = '0;
    wh_addr_i   = `GAT_DBG_CAP_ADDR_A;
    sppe_i[`GAT_DBG_SPPE_LANE] = 12'habc;
    @(negedge clk);
    wh_addr_i = '0;
    read_word(`GAT_DBG_REG_CAP_A);
    read_word(`GAT_DBG_REG_CAP_B);
    end_test();

    start_test("feature_watch");
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      feat_ena_i  = 1'b1;
      feat_addr_i = feat_addr_t'(43327 - i * 10000);
    end
    @(negedge clk);
    feat_ena_i  = 1'b0;
    feat_addr_i = `GAT_DBG_FEAT_HI_ADDR;
    read_word(`GAT_DBG_REG_STATUS);
    @(negedge clk);
    feat_ena_i = 1'b1;
    @(negedge clk);
    feat_ena_i = 1'b0;
    read_word(`GAT_DBG_REG_STATUS);
    end_test();

    start_test("freeze_clear");
    pulse_control(1'b0, 1'b1, 1'b0);
    repeat (20)
      drive_strobes(stage_vec_t'($random(seed)), stage_vec_t'($random(seed)));
    drive_strobes('0, '0);
    for (int i = 2; i <= 12; i++)
      read_word(reg_sel_t'(i));
    pulse_control(1'b0, 1'b0, 1'b1);
    for (int i = 0; i <= 12; i++)
      read_word(reg_sel_t'(i));
    end_test();

    repeat (2) @(negedge clk);
    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tests/gat_debugger_sva.sv
`include "gat_debug_defs.svh"

module gat_debugger_sva (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  gat_debug_pkg::reg_sel_t                           sel_i,
  input  gat_debug_pkg::dbg_word_t                          rdata_i,
  input  gat_debug_pkg::dbg_state_e                         state_i,
  input  gat_debug_pkg::dbg_cnt_t [`GAT_DBG_NUM_STAGES-1:0] xfer_cnt_i,
  input  gat_debug_pkg::dbg_cnt_t [`GAT_DBG_NUM_STAGES-1:0] stall_cnt_i
);

  import gat_debug_pkg::*;

  // ==============================
  // Readout
  // ==============================
  // The word asked for one cycle earlier.
  a_read_word: assert property (@(posedge clk) disable iff (!rst_n)
    tb_gat_debugger.chk_en |-> rdata_i == tb_gat_debugger.exp_word
  ) else begin
    $error("** Error %s: expected %h, actual %h", tb_gat_debugger.test_name,
           $sampled(tb_gat_debugger.exp_word), $sampled(rdata_i));
    tb_gat_debugger.err_cnt++;
  end

  // Indices past the last register read zero.
  a_unused_zero: assert property (@(posedge clk) disable iff (!rst_n)
    $past(sel_i) > `GAT_DBG_REG_CAP_B |-> rdata_i == '0
  ) else begin
    $error("** Error %s: expected 0, actual %h", tb_gat_debugger.test_name,
           $sampled(rdata_i));
    tb_gat_debugger.err_cnt++;
  end

  // ==============================
  // Recorded state against the model
  // ==============================
  a_state: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == tb_gat_debugger.ref_state
  ) else begin
    $error("** Error %s: expected state %0d, actual %0d", tb_gat_debugger.test_name,
           $sampled(tb_gat_debugger.ref_state), $sampled(state_i));
    tb_gat_debugger.err_cnt++;
  end

  a_xfer_cnt: assert property (@(posedge clk) disable iff (!rst_n)
    xfer_cnt_i == tb_gat_debugger.ref_xfer
  ) else begin
    $error("** Error %s: expected transfers %h, actual %h", tb_gat_debugger.test_name,
           $sampled(tb_gat_debugger.ref_xfer), $sampled(xfer_cnt_i));
    tb_gat_debugger.err_cnt++;
  end

  a_stall_cnt: assert property (@(posedge clk) disable iff (!rst_n)
    stall_cnt_i == tb_gat_debugger.ref_stall
  ) else begin
    $error("** Error %s: expected stalls %h, actual %h", tb_gat_debugger.test_name,
           $sampled(tb_gat_debugger.ref_stall), $sampled(stall_cnt_i));
    tb_gat_debugger.err_cnt++;
  end

endmodule

//--- rtl/gat_debugger.sv
`include "gat_debug_defs.svh"

module gat_debugger #(
  parameter int NUM_SPARSE_DATA = 12
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             arm_i,
  input  logic                             freeze_i,
  input  logic                             clear_i,
  input  gat_debug_pkg::stage_vec_t        stage_vld_i,
  input  gat_debug_pkg::stage_vec_t        stage_rdy_i,
  input  gat_debug_pkg::wh_addr_t          wh_addr_i,
  input  gat_debug_pkg::sppe_lane_t [15:0] sppe_i,
  input  logic                             feat_ena_i,
  input  gat_debug_pkg::feat_addr_t        feat_addr_i,
  input  gat_debug_pkg::reg_sel_t          sel_i,
  output gat_debug_pkg::dbg_word_t         rdata_o,
  output gat_debug_pkg::dbg_state_e        state_o
);

  logic                                              rec_en;
  logic                                              clr;
  gat_debug_pkg::stage_vec_t                         vld_seen;
  gat_debug_pkg::stage_vec_t                         rdy_seen;
  gat_debug_pkg::dbg_cnt_t [`GAT_DBG_NUM_STAGES-1:0] xfer_cnt;
  gat_debug_pkg::dbg_cnt_t [`GAT_DBG_NUM_STAGES-1:0] stall_cnt;
  gat_debug_pkg::sppe_lane_t                         cap_a;
  gat_debug_pkg::sppe_lane_t                         cap_b;
  logic                                              feat_wr_seen;
  logic                                              feat_hi_seen;

  debug_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .arm_i    (arm_i),
    .freeze_i (freeze_i),
    .clear_i  (clear_i),
    .rec_en_o (rec_en),
    .clr_o    (clr),
    .state_o  (state_o)
  );

  // ==============================
  // One monitor per stage
  // ==============================
  for (genvar s = 0; s < `GAT_DBG_NUM_STAGES; s++) begin : g_stage
    stage_hs_monitor u_mon (
      .clk         (clk),
      .rst_n       (rst_n),
      .vld_i       (stage_vld_i[s]),
      .rdy_i       (stage_rdy_i[s]),
      .rec_en_i    (rec_en),
      .clr_i       (clr),
      .vld_seen_o  (vld_seen[s]),
      .rdy_seen_o  (rdy_seen[s]),
      .xfer_cnt_o  (xfer_cnt[s]),
      .stall_cnt_o (stall_cnt[s])
    );
  end

  // Bit 0 of the ready vector is the spmm stage.
  bram_watch u_watch (
    .clk            (clk),
    .rst_n          (rst_n),
    .rec_en_i       (rec_en),
    .clr_i          (clr),
    .spmm_rdy_i     (stage_rdy_i[0]),
    .feat_ena_i     (feat_ena_i),
    .wh_addr_i      (wh_addr_i),
    .sppe_i         (sppe_i),
    .feat_addr_i    (feat_addr_i),
    .cap_a_o        (cap_a),
    .cap_b_o        (cap_b),
    .feat_wr_seen_o (feat_wr_seen),
    .feat_hi_seen_o (feat_hi_seen)
  );

  debug_readout #(
    .NUM_SPARSE_DATA (NUM_SPARSE_DATA)
  ) u_readout (
    .clk            (clk),
    .rst_n          (rst_n),
    .sel_i          (sel_i),
    .vld_seen_i     (vld_seen),
    .rdy_seen_i     (rdy_seen),
    .xfer_cnt_i     (xfer_cnt),
    .stall_cnt_i    (stall_cnt),
    .cap_a_i        (cap_a),
    .cap_b_i        (cap_b),
    .feat_wr_seen_i (feat_wr_seen),
    .feat_hi_seen_i (feat_hi_seen),
    .state_i        (state_o),
    .rdata_o        (rdata_o)
  );

endmodule

//--- rtl/debug_readout.sv
`include "gat_debug_defs.svh"

module debug_readout #(
  parameter int NUM_SPARSE_DATA = 12
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  gat_debug_pkg::reg_sel_t                              sel_i,
  input  gat_debug_pkg::stage_vec_t                            vld_seen_i,
  input  gat_debug_pkg::stage_vec_t                            rdy_seen_i,
  input  gat_debug_pkg::dbg_cnt_t [`GAT_DBG_NUM_STAGES-1:0]    xfer_cnt_i,
  input  gat_debug_pkg::dbg_cnt_t [`GAT_DBG_NUM_STAGES-1:0]    stall_cnt_i,
  input  gat_debug_pkg::sppe_lane_t                            cap_a_i,
  input  gat_debug_pkg::sppe_lane_t                            cap_b_i,
  input  logic                                                 feat_wr_seen_i,
  input  logic                                                 feat_hi_seen_i,
  input  gat_debug_pkg::dbg_state_e                            state_i,
  output gat_debug_pkg::dbg_word_t                             rdata_o
);

  import gat_debug_pkg::*;

  localparam int NS = `GAT_DBG_NUM_STAGES;

  dbg_word_t status_w;
  dbg_word_t word_d;
  dbg_word_t rdata_q;

  // ==============================
  // Status word
  // ==============================
  // Spmm sits in the top flag pair, aggr in the bottom one.
  always_comb begin
    status_w = '0;
    for (int i = 0; i < NS; i++) begin
      status_w[2*NS-1-2*i] = vld_seen_i[i];
      status_w[2*NS-2-2*i] = rdy_seen_i[i];
    end
    status_w[8]     = feat_wr_seen_i;
    status_w[9]     = feat_hi_seen_i;
    status_w[11:10] = state_i;
  end

  // ==============================
  // Word select
  // ==============================
  always_comb begin
    word_d = '0;
    case (sel_i)
      `GAT_DBG_REG_ID:     word_d = `GAT_DBG_SIGNATURE;
      `GAT_DBG_REG_CFG:    word_d = dbg_word_t'(NUM_SPARSE_DATA);
      `GAT_DBG_REG_STATUS: word_d = status_w;
      `GAT_DBG_REG_CAP_A:  word_d = dbg_word_t'(cap_a_i);
      `GAT_DBG_REG_CAP_B:  word_d = dbg_word_t'(cap_b_i);
      default:             word_d = '0;
    endcase
    // Counter banks, one index per stage in stage order.
    for (int i = 0; i < NS; i++) begin
      if (sel_i == reg_sel_t'(`GAT_DBG_REG_XFER0 + i)) begin
        word_d = dbg_word_t'(xfer_cnt_i[i]);
      end
      if (sel_i == reg_sel_t'(`GAT_DBG_REG_STALL0 + i)) begin
        word_d = dbg_word_t'(stall_cnt_i[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= word_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- rtl/bram_watch.sv
`include "gat_debug_defs.svh"

module bram_watch (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             rec_en_i,
  input  logic                             clr_i,
  input  logic                             spmm_rdy_i,
  input  logic                             feat_ena_i,
  input  gat_debug_pkg::wh_addr_t          wh_addr_i,
  input  gat_debug_pkg::sppe_lane_t [15:0] sppe_i,
  input  gat_debug_pkg::feat_addr_t        feat_addr_i,
  output gat_debug_pkg::sppe_lane_t        cap_a_o,
  output gat_debug_pkg::sppe_lane_t        cap_b_o,
  output logic                             feat_wr_seen_o,
  output logic                             feat_hi_seen_o
);

  import gat_debug_pkg::*;

  sppe_lane_t lane;
  sppe_lane_t cap_a_q;
  sppe_lane_t cap_b_q;
  logic       hit_a;
  logic       hit_b;
  logic       feat_wr;
  logic       feat_hi;
  logic       feat_wr_seen_q;
  logic       feat_hi_seen_q;

  assign lane  = sppe_i[`GAT_DBG_SPPE_LANE];
  assign hit_a = rec_en_i && spmm_rdy_i && (wh_addr_i == `GAT_DBG_CAP_ADDR_A);
  assign hit_b = rec_en_i && spmm_rdy_i && (wh_addr_i == `GAT_DBG_CAP_ADDR_B);

  // ==============================
  // Sparse-PE lane capture
  // ==============================
  // Each hit overwrites, so the last match is kept.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else if (clr_i) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else begin
      if (hit_a) cap_a_q <= lane;
      if (hit_b) cap_b_q <= lane;
    end
  end

  // ==============================
  // Feature BRAM write watch
  // ==============================
  assign feat_wr = rec_en_i && feat_ena_i;
  assign feat_hi = feat_wr && (feat_addr_i >= `GAT_DBG_FEAT_HI_ADDR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_wr_seen_q <= 1'b0;
      feat_hi_seen_q <= 1'b0;
    end else if (clr_i) begin
      feat_wr_seen_q <= 1'b0;
      feat_hi_seen_q <= 1'b0;
    end else begin
      feat_wr_seen_q <= feat_wr_seen_q | feat_wr;
      feat_hi_seen_q <= feat_hi_seen_q | feat_hi;
    end
  end

  assign cap_a_o        = cap_a_q;
  assign cap_b_o        = cap_b_q;
  assign feat_wr_seen_o = feat_wr_seen_q;
  assign feat_hi_seen_o = feat_hi_seen_q;

endmodule

//--- rtl/stage_hs_monitor.sv
module stage_hs_monitor (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    vld_i,
  input  logic                    rdy_i,
  input  logic                    rec_en_i,
  input  logic                    clr_i,
  output logic                    vld_seen_o,
  output logic                    rdy_seen_o,
  output gat_debug_pkg::dbg_cnt_t xfer_cnt_o,
  output gat_debug_pkg::dbg_cnt_t stall_cnt_o
);

  import gat_debug_pkg::*;

  logic     vld_seen_q;
  logic     rdy_seen_q;
  dbg_cnt_t xfer_q;
  dbg_cnt_t stall_q;
  logic     is_xfer;
  logic     is_stall;

  assign is_xfer  = vld_i & rdy_i;
  assign is_stall = vld_i & ~rdy_i;

  // ==============================
  // Sticky handshake flags
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_seen_q <= 1'b0;
      rdy_seen_q <= 1'b0;
    end else if (clr_i) begin
      vld_seen_q <= 1'b0;
      rdy_seen_q <= 1'b0;
    end else if (rec_en_i) begin
      vld_seen_q <= vld_seen_q | vld_i;
      rdy_seen_q <= rdy_seen_q | rdy_i;
    end
  end

  // ==============================
  // Transfer and stall counters
  // ==============================
  // Counters wrap silently.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      xfer_q  <= '0;
      stall_q <= '0;
    end else if (clr_i) begin
      xfer_q  <= '0;
      stall_q <= '0;
    end else if (rec_en_i) begin
      if (is_xfer) begin
        xfer_q <= xfer_q + 1'b1;
      end
      if (is_stall) begin
        stall_q <= stall_q + 1'b1;
      end
    end
  end

  assign vld_seen_o  = vld_seen_q;
  assign rdy_seen_o  = rdy_seen_q;
  assign xfer_cnt_o  = xfer_q;
  assign stall_cnt_o = stall_q;

endmodule

//--- rtl/debug_ctrl.sv
module debug_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     arm_i,
  input  logic                     freeze_i,
  input  logic                     clear_i,
  output logic                     rec_en_o,
  output logic                     clr_o,
  output gat_debug_pkg::dbg_state_e state_o
);

  import gat_debug_pkg::*;

  dbg_state_e state_q;
  dbg_state_e state_d;

  // Clear wins over freeze, freeze over arm.
  always_comb begin
    state_d = state_q;
    if (clear_i) begin
      state_d = DBG_IDLE;
    end else begin
      case (state_q)
        DBG_IDLE: begin
          if (arm_i) begin
            state_d = DBG_ARMED;
          end
        end
        DBG_ARMED: begin
          if (freeze_i) begin
            state_d = DBG_FROZEN;
          end
        end
        DBG_FROZEN: begin
          state_d = DBG_FROZEN;
        end
        default: begin
          state_d = DBG_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DBG_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Only the armed state lets recorded state change.
  assign rec_en_o = (state_q == DBG_ARMED);

  // One-cycle clear, taken in the same cycle as clear_i.
  assign clr_o    = clear_i;

  assign state_o  = state_q;

endmodule

//--- rtl/gat_debug_pkg.sv
`include "gat_debug_defs.svh"

package gat_debug_pkg;

  // ==============================
  // Data widths
  // ==============================
  typedef logic [31:0]                    dbg_word_t;
  typedef logic [`GAT_DBG_CNT_W-1:0]      dbg_cnt_t;
  typedef logic [11:0]                    sppe_lane_t;
  typedef logic [13:0]                    wh_addr_t;
  typedef logic [15:0]                    feat_addr_t;
  typedef logic [3:0]                     reg_sel_t;
  typedef logic [`GAT_DBG_NUM_STAGES-1:0] stage_vec_t;

  // ==============================
  // Controller states
  // ==============================
  // Encoding is visible in the status word.
  typedef enum logic [1:0] {
    DBG_IDLE   = 2'd0,
    DBG_ARMED  = 2'd1,
    DBG_FROZEN = 2'd2
  } dbg_state_e;

endpackage

//--- rtl/gat_debug_defs.svh
`ifndef GAT_DEBUG_DEFS_SVH
`define GAT_DEBUG_DEFS_SVH

// Observed stages: spmm, dmvm, sm, aggr.
`define GAT_DBG_NUM_STAGES   4
`define GAT_DBG_CNT_W        32

// Weight addresses that trigger a sparse-PE lane capture.
`define GAT_DBG_CAP_ADDR_A   14'd10
`define GAT_DBG_CAP_ADDR_B   14'd20
`define GAT_DBG_SPPE_LANE    2

// First feature address past the node-feature region.
`define GAT_DBG_FEAT_HI_ADDR 16'd43328

`define GAT_DBG_SIGNATURE    32'd15422103

// Readout indices.
`define GAT_DBG_REG_ID       4'd0
`define GAT_DBG_REG_CFG      4'd1
`define GAT_DBG_REG_STATUS   4'd2
`define GAT_DBG_REG_XFER0    4'd3
`define GAT_DBG_REG_STALL0   4'd7
`define GAT_DBG_REG_CAP_A    4'd11
`define GAT_DBG_REG_CAP_B    4'd12

`endif
